/* list.f */
+incdir+design
+incdir+verif
design/isa_pkg.sv
design/pipe_pkg.sv
design/stage_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/writeback_stage.sv
design/rv_core.sv
verif/core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/stage_if.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/writeback_stage.sv
      - design/rv_core.sv
  - target: simulation
    include_dirs:
      - design
      - verif
    files:
      - verif/core_tb.sv

/* verif/core_ref_model.svh */
// reference isa model and random program image for the core testbench
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

logic [`INST_W-1:0]     prog [IMEM_WORDS];
logic [`XLEN-1:0]       ref_mem [DMEM_WORDS];
logic [`XLEN-1:0]       exp_pc [$];
logic                   exp_wen [$];
logic [`REG_ADDR_W-1:0] exp_rd [$];
logic [`XLEN-1:0]       exp_data [$];

// initial data memory contents for the model and the testbench array
function automatic logic [`XLEN-1:0] fill_word(input int idx);
  return {32'(idx) * 32'h9e3779b9, ~32'(idx)};
endfunction

function automatic logic [`INST_W-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [`INST_W-1:0] i_type(input opcode_e opc, input logic [2:0] f3,
                                              input logic [4:0] rd, rs1,
                                              input logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

// sd only
function automatic logic [`INST_W-1:0] s_type(input logic [4:0] rs2, rs1,
                                              input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
endfunction

function automatic logic [`INST_W-1:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [`INST_W-1:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic void build_program();
  logic [11:0] imm_a;
  logic [11:0] imm_b;
  logic [11:0] imm_c;
  logic [5:0]  shamt;
  logic [11:0] base;
  imm_a = 12'($random(seed));
  imm_b = 12'($random(seed));
  imm_c = 12'($random(seed));
  shamt = 6'($random(seed));
  // doubleword aligned with room for the +24 offset
  base  = {5'd0, 4'($random(seed)), 3'd0};
  for (int i = 0; i < IMEM_WORDS; i++) begin
    prog[i] = i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'(i));
  end
  // dependent alu chain
  prog[0]  = i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, imm_a);
  prog[1]  = i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, imm_b);
  prog[2]  = r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
  prog[3]  = r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);
  prog[4]  = r_type(7'h00, 3'b100, 5'd5, 5'd4, 5'd3);
  prog[5]  = r_type(7'h00, 3'b111, 5'd6, 5'd5, 5'd4);
  prog[6]  = r_type(7'h00, 3'b110, 5'd7, 5'd6, 5'd5);
  prog[7]  = r_type(7'h00, 3'b010, 5'd8, 5'd7, 5'd1);
  prog[8]  = i_type(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, {6'd0, shamt});
  prog[9]  = r_type(7'h00, 3'b001, 5'd9, 5'd3, 5'd10);
  prog[10] = r_type(7'h00, 3'b101, 5'd11, 5'd9, 5'd10);
  // store, load back, load-use add
  prog[11] = i_type(OPC_OP_IMM, 3'b000, 5'd12, 5'd0, base);
  prog[12] = s_type(5'd9, 5'd12, 12'd0);
  prog[13] = i_type(OPC_LOAD, 3'b011, 5'd13, 5'd12, 12'd0);
  prog[14] = r_type(7'h00, 3'b000, 5'd14, 5'd13, 5'd1);
  prog[15] = s_type(5'd14, 5'd12, 12'd8);
  prog[16] = i_type(OPC_LOAD, 3'b011, 5'd15, 5'd12, 12'd8);
  // taken beq skips a store and an addi
  prog[17] = b_type(3'b000, 5'd15, 5'd14, 13'd12);
  prog[18] = s_type(5'd1, 5'd12, 12'd24);
  prog[19] = i_type(OPC_OP_IMM, 3'b000, 5'd21, 5'd0, 12'd2);
  prog[20] = b_type(3'b001, 5'd1, 5'd1, 13'd12);
  prog[21] = i_type(OPC_OP_IMM, 3'b000, 5'd17, 5'd0, imm_c | 12'd1);
  // taken bne skips a load and an addi
  prog[22] = b_type(3'b001, 5'd17, 5'd0, 13'd12);
  prog[23] = i_type(OPC_LOAD, 3'b011, 5'd22, 5'd12, 12'd0);
  prog[24] = i_type(OPC_OP_IMM, 3'b000, 5'd23, 5'd0, 12'd4);
  prog[25] = b_type(3'b000, 5'd17, 5'd0, 13'd8);
  prog[26] = j_type(5'd18, 21'd8);
  prog[27] = i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'd6);
  prog[28] = r_type(7'h00, 3'b000, 5'd19, 5'd18, 5'd17);
  prog[29] = s_type(5'd19, 5'd12, 12'd16);
  prog[30] = j_type(5'd0, 21'd0);
endfunction

// runs the program in order up to the jal to itself
function automatic void ref_run();
  logic [`XLEN-1:0]   x [`NUM_REGS];
  logic [`XLEN-1:0]   pc, next_pc, a, b, val, addr;
  logic [`XLEN-1:0]   imm_i, imm_s, imm_b, imm_j;
  logic [`INST_W-1:0] inst;
  logic [4:0]         rd;
  logic               wen;
  logic               done;
  for (int i = 0; i < `NUM_REGS; i++) begin
    x[i] = '0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    ref_mem[i] = fill_word(i);
  end
  pc   = `PC_RESET;
  done = 1'b0;
  while (!done) begin
    inst    = prog[pc[IMEM_AW+1:2]];
    rd      = inst[11:7];
    a       = x[inst[19:15]];
    b       = x[inst[24:20]];
    imm_i   = {{52{inst[31]}}, inst[31:20]};
    imm_s   = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = pc + 64'd4;
    wen     = 1'b0;
    val     = '0;
    case (inst[6:0])
      OPC_OP: begin
        wen = 1'b1;
        case (inst[14:12])
          3'b000:  val = inst[30] ? a - b : a + b;
          3'b111:  val = a & b;
          3'b110:  val = a | b;
          3'b100:  val = a ^ b;
          3'b010:  val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'b001:  val = a << b[5:0];
          default: val = a >> b[5:0];
        endcase
      end
      OPC_OP_IMM: begin
        wen = 1'b1;
        val = a + imm_i;
      end
      OPC_LOAD: begin
        wen  = 1'b1;
        addr = a + imm_i;
        val  = ref_mem[addr[DMEM_AW+2:3]];
      end
      OPC_STORE: begin
        addr = a + imm_s;
        ref_mem[addr[DMEM_AW+2:3]] = b;
      end
      OPC_BRANCH: begin
        if ((inst[14:12] == 3'b000) ? (a == b) : (a != b))
          next_pc = pc + imm_b;
      end
      OPC_JAL: begin
        wen     = 1'b1;
        val     = pc + 64'd4;
        next_pc = pc + imm_j;
        done    = (imm_j == '0);
      end
      default: ;
    endcase
    wen = wen && (rd != 5'd0);
    if (wen)
      x[rd] = val;
    exp_pc.push_back(pc);
    exp_wen.push_back(wen);
    exp_rd.push_back(rd);
    exp_data.push_back(val);
    pc = next_pc;
  end
endfunction

`endif

/* verif/core_tb.sv */
// testbench for the rv64i pipeline that checks commits and memory against an isa model
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb import isa_pkg::*; ();

  localparam int RESET_CYCLES = 4;
  localparam int IMEM_AW      = 6;
  localparam int IMEM_WORDS   = 1 << IMEM_AW;
  localparam int DMEM_AW      = 5;
  localparam int DMEM_WORDS   = 1 << DMEM_AW;

  logic                   clock;
  logic                   reset;
  logic [`XLEN-1:0]       imem_addr;
  logic [`INST_W-1:0]     imem_data;
  logic [`XLEN-1:0]       dmem_addr;
  logic                   dmem_read;
  logic                   dmem_write;
  logic [`XLEN-1:0]       dmem_wdata;
  logic [`XLEN-1:0]       dmem_rdata;
  logic                   commit_valid;
  logic [`XLEN-1:0]       commit_pc;
  logic                   commit_wen;
  logic [`REG_ADDR_W-1:0] commit_rd;
  logic [`XLEN-1:0]       commit_data;

  logic [`XLEN-1:0] dmem [DMEM_WORDS];
  integer           seed = 32'h9aa2266d;
  logic             model_ready = 1'b0;
  logic             last_read = 1'b0;
  logic             last_write = 1'b0;
  logic [6:0]       exp_opc;
  int               commit_idx = 0;

  `include "core_ref_model.svh"

  rv_core dut0 (
    .clock        (clock),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dmem_addr    (dmem_addr),
    .dmem_read    (dmem_read),
    .dmem_write   (dmem_write),
    .dmem_wdata   (dmem_wdata),
    .dmem_rdata   (dmem_rdata),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  always #4 clock = ~clock;

  // both memories read in the same cycle
  assign imem_data  = prog[imem_addr[IMEM_AW+1:2]];
  assign dmem_rdata = dmem[dmem_addr[DMEM_AW+2:3]];

  always @(posedge clock) begin
    if (dmem_write)
      dmem[dmem_addr[DMEM_AW+2:3]] <= dmem_wdata;
  end

  task automatic stop_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic value_error(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] expected);
    $display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
    stop_with_failure();
  endtask

  task automatic run_error(input string what);
    $display("error at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  // outputs are settled by the falling edge
  // a strobe in the memory stage shows up as a commit one cycle later
  always @(negedge clock) begin
    if (!reset && model_ready) begin
      if (commit_valid && commit_idx < exp_pc.size()) begin
        assert (commit_pc == exp_pc[commit_idx])
          else value_error("commit_pc", commit_pc, exp_pc[commit_idx]);
        assert (commit_wen == exp_wen[commit_idx])
          else value_error("commit_wen", commit_wen, exp_wen[commit_idx]);
        exp_opc = prog[exp_pc[commit_idx][IMEM_AW+1:2]][6:0];
        assert (last_read == (exp_opc == OPC_LOAD))
          else value_error("dmem_read", last_read, exp_opc == OPC_LOAD);
        assert (last_write == (exp_opc == OPC_STORE))
          else value_error("dmem_write", last_write, exp_opc == OPC_STORE);
        // rd and data only mean something on a register write
        if (exp_wen[commit_idx]) begin
          assert (commit_rd == exp_rd[commit_idx])
            else value_error("commit_rd", commit_rd, exp_rd[commit_idx]);
          assert (commit_data == exp_data[commit_idx])
            else value_error("commit_data", commit_data, exp_data[commit_idx]);
        end
        commit_idx = commit_idx + 1;
      end else if (!commit_valid) begin
        assert (!last_read && !last_write)
          else run_error("data memory strobe high with no instruction behind it");
      end
      if (dmem_read || dmem_write) begin
        assert (dmem_addr < DMEM_WORDS * 8 && dmem_addr[2:0] == 3'd0)
          else run_error("data access outside the data memory or misaligned");
      end
      last_read  = dmem_read;
      last_write = dmem_write;
    end
  end

  initial begin
    wait (model_ready);
    repeat (5 * exp_pc.size() + RESET_CYCLES) @(posedge clock);
    run_error("the commits did not complete before the watchdog limit");
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    build_program();
    ref_run();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(i);
    end
    model_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    wait (commit_idx == exp_pc.size());
    for (int i = 0; i < DMEM_WORDS; i++) begin
      assert (dmem[i] == ref_mem[i])
        else value_error($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* design/rv_core.sv */
// rv64i five-stage core top with instruction, data and commit ports
`timescale 1ns/1ps
`include "core_params.svh"

module rv_core (
  input  logic                   clock,
  input  logic                   reset,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic [`INST_W-1:0]     imem_data,
  output logic [`XLEN-1:0]       dmem_addr,
  output logic                   dmem_read,
  output logic                   dmem_write,
  output logic [`XLEN-1:0]       dmem_wdata,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic                   commit_valid,
  output logic [`XLEN-1:0]       commit_pc,
  output logic                   commit_wen,
  output logic [`REG_ADDR_W-1:0] commit_rd,
  output logic [`XLEN-1:0]       commit_data
);

  logic                   fd_valid;
  logic [`XLEN-1:0]       fd_pc;
  logic [`INST_W-1:0]     fd_inst;
  logic                   stall;
  logic                   redirect;
  logic [`XLEN-1:0]       target;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  stage_if dx_bus ();
  stage_if xm_bus ();
  stage_if mw_bus ();

  fetch_stage fetch0 (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .target    (target),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .fd_valid  (fd_valid),
    .fd_pc     (fd_pc),
    .fd_inst   (fd_inst)
  );

  decode_stage decode0 (
    .clock    (clock),
    .reset    (reset),
    .fd_valid (fd_valid),
    .fd_pc    (fd_pc),
    .fd_inst  (fd_inst),
    .redirect (redirect),
    .stall    (stall),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dx       (dx_bus.source)
  );

  execute_stage execute0 (
    .clock    (clock),
    .reset    (reset),
    .dx       (dx_bus.sink),
    .xm       (xm_bus.source),
    .mw       (mw_bus.monitor),
    .redirect (redirect),
    .target   (target)
  );

  memory_stage memory0 (
    .clock      (clock),
    .reset      (reset),
    .xm         (xm_bus.sink),
    .mw         (mw_bus.source),
    .dmem_addr  (dmem_addr),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata)
  );

  writeback_stage writeback0 (
    .clock        (clock),
    .reset        (reset),
    .mw           (mw_bus.sink),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .commit_valid (commit_valid),
    .commit_wen   (commit_wen),
    .commit_pc    (commit_pc),
    .commit_data  (commit_data),
    .commit_rd    (commit_rd)
  );

endmodule

/* design/writeback_stage.sv */
// writeback stage with the register file and the commit port
`timescale 1ns/1ps
`include "core_params.svh"

module writeback_stage (
  input  logic                   clock,
  input  logic                   reset,
  stage_if.sink                  mw,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  output logic                   commit_valid,
  output logic                   commit_wen,
  output logic [`XLEN-1:0]       commit_pc,
  output logic [`XLEN-1:0]       commit_data,
  output logic [`REG_ADDR_W-1:0] commit_rd
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             wen;

  assign wen = mw.valid && mw.uop.reg_write;

  // write-through so decode sees this cycle's result
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    else if (wen && mw.uop.rd == addr)
      return mw.result;
    else
      return regs[addr];
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[mw.uop.rd] <= mw.result;
    end
  end

  assign commit_valid = mw.valid;
  assign commit_wen   = wen;
  assign commit_pc    = mw.pc;
  assign commit_data  = mw.result;
  assign commit_rd    = mw.uop.rd;

  // x0 writes are dropped back in decode
  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    commit_wen |-> commit_rd != '0);

endmodule

/* design/memory_stage.sv */
// memory stage driving the data port and the memory to writeback register
`timescale 1ns/1ps
`include "core_params.svh"

module memory_stage (
  input  logic             clock,
  input  logic             reset,
  stage_if.sink            xm,
  stage_if.source          mw,
  output logic [`XLEN-1:0] dmem_addr,
  output logic             dmem_read,
  output logic             dmem_write,
  output logic [`XLEN-1:0] dmem_wdata,
  input  logic [`XLEN-1:0] dmem_rdata
);

  assign dmem_addr  = xm.result;
  assign dmem_read  = xm.valid && xm.uop.mem_read;
  assign dmem_write = xm.valid && xm.uop.mem_write;
  assign dmem_wdata = xm.store_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      mw.valid <= 1'b0;
    end else begin
      mw.valid <= xm.valid;
    end
  end

  always_ff @(posedge clock) begin
    mw.pc         <= xm.pc;
    mw.uop        <= xm.uop;
    mw.result     <= xm.uop.mem_read ? dmem_rdata : xm.result;
    mw.store_data <= xm.store_data;
  end

  // decode never marks one op as both load and store
  a_rw_excl: assert property (@(posedge clock) disable iff (reset)
    !(dmem_read && dmem_write));

endmodule

/* design/execute_stage.sv */
// execute stage with operand forwarding, alu and branch resolution
`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  stage_if.sink            dx,
  stage_if.source          xm,
  stage_if.monitor         mw,
  output logic             redirect,
  output logic [`XLEN-1:0] target
);

  fwd_sel_e         sel1;
  fwd_sel_e         sel2;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_rs2;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] link;
  logic             taken;

  // younger producer first, loads in xm are covered by the stall
  function automatic fwd_sel_e pick_src(input logic [`REG_ADDR_W-1:0] rs);
    if (xm.valid && xm.uop.reg_write && !xm.uop.mem_read && xm.uop.rd == rs)
      return FWD_MEM;
    else if (mw.valid && mw.uop.reg_write && mw.uop.rd == rs)
      return FWD_WB;
    else
      return FWD_REG;
  endfunction

  function automatic logic [`XLEN-1:0] operand(input fwd_sel_e sel,
                                               input logic [`XLEN-1:0] reg_val);
    case (sel)
      FWD_MEM: return xm.result;
      FWD_WB:  return mw.result;
      default: return reg_val;
    endcase
  endfunction

  assign sel1   = pick_src(dx.uop.rs1);
  assign sel2   = pick_src(dx.uop.rs2);
  assign op_a   = operand(sel1, dx.result);
  assign op_rs2 = operand(sel2, dx.store_data);
  assign op_b   = dx.uop.use_imm ? dx.uop.imm : op_rs2;

  always_comb begin
    case (dx.uop.alu_op)
      ALU_ADD: alu_out = op_a + op_b;
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_XOR: alu_out = op_a ^ op_b;
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLL: alu_out = op_a << op_b[`SHAMT_W-1:0];
      default: alu_out = op_a >> op_b[`SHAMT_W-1:0];
    endcase
  end

  always_comb begin
    case (dx.uop.branch)
      BR_BEQ:  taken = (op_a == op_rs2);
      BR_BNE:  taken = (op_a != op_rs2);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign link     = dx.pc + `XLEN'd4;
  assign target   = dx.pc + dx.uop.imm;
  assign redirect = dx.valid && taken;

  always_ff @(posedge clock) begin
    if (reset) begin
      xm.valid <= 1'b0;
    end else begin
      xm.valid <= dx.valid;
    end
  end

  always_ff @(posedge clock) begin
    xm.pc         <= dx.pc;
    xm.uop        <= dx.uop;
    xm.result     <= (dx.uop.branch == BR_JUMP) ? link : alu_out;
    xm.store_data <= op_rs2;
  end

endmodule

/* design/decode_stage.sv */
// decode stage with load-use detection and the decode to execute register
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fd_valid,
  input  logic [`XLEN-1:0]       fd_pc,
  input  logic [`INST_W-1:0]     fd_inst,
  input  logic                   redirect,
  output logic                   stall,
  output logic [`REG_ADDR_W-1:0] rs1_addr,
  output logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`XLEN-1:0]       rs1_data,
  input  logic [`XLEN-1:0]       rs2_data,
  stage_if.source                dx
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       uses_rs1;
  logic       uses_rs2;
  uop_t       uop;

  assign opcode = opcode_e'(fd_inst[6:0]);
  assign funct3 = fd_inst[14:12];

  always_comb begin
    uop       = '0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    uop.rd    = fd_inst[11:7];
    uop.imm   = {{(`XLEN-12){fd_inst[31]}}, fd_inst[31:20]};
    case (opcode)
      OPC_OP: begin
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        uop.reg_write = 1'b1;
        case (funct3)
          3'b000:  uop.alu_op = fd_inst[30] ? ALU_SUB : ALU_ADD;
          3'b111:  uop.alu_op = ALU_AND;
          3'b110:  uop.alu_op = ALU_OR;
          3'b100:  uop.alu_op = ALU_XOR;
          3'b010:  uop.alu_op = ALU_SLT;
          3'b001:  uop.alu_op = ALU_SLL;
          default: uop.alu_op = ALU_SRL;
        endcase
      end
      // addi only
      OPC_OP_IMM: begin
        uses_rs1      = 1'b1;
        uop.reg_write = (funct3 == 3'b000);
        uop.use_imm   = 1'b1;
      end
      OPC_LOAD: begin
        uses_rs1      = 1'b1;
        uop.reg_write = (funct3 == 3'b011);
        uop.mem_read  = (funct3 == 3'b011);
        uop.use_imm   = 1'b1;
      end
      OPC_STORE: begin
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        uop.mem_write = (funct3 == 3'b011);
        uop.use_imm   = 1'b1;
        uop.imm = {{(`XLEN-12){fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]};
      end
      OPC_BRANCH: begin
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b1;
        uop.branch = (funct3 == 3'b000) ? BR_BEQ :
                     (funct3 == 3'b001) ? BR_BNE : BR_NONE;
        uop.imm = {{(`XLEN-12){fd_inst[31]}}, fd_inst[7], fd_inst[30:25],
                   fd_inst[11:8], 1'b0};
      end
      OPC_JAL: begin
        uop.reg_write = 1'b1;
        uop.branch    = BR_JUMP;
        uop.imm = {{(`XLEN-20){fd_inst[31]}}, fd_inst[19:12], fd_inst[20],
                   fd_inst[30:21], 1'b0};
      end
      default: ;
    endcase
    uop.rs1       = uses_rs1 ? fd_inst[19:15] : '0;
    uop.rs2       = uses_rs2 ? fd_inst[24:20] : '0;
    // x0 destinations never write, so later stages skip the rd check
    uop.reg_write = uop.reg_write && (uop.rd != '0);
  end

  assign rs1_addr = uop.rs1;
  assign rs2_addr = uop.rs2;

  // load in execute feeding this instruction
  assign stall = fd_valid && dx.valid && dx.uop.mem_read && dx.uop.reg_write &&
                 ((dx.uop.rd == uop.rs1) || (dx.uop.rd == uop.rs2));

  always_ff @(posedge clock) begin
    if (reset) begin
      dx.valid <= 1'b0;
    end else begin
      dx.valid <= fd_valid && !stall && !redirect;
    end
  end

  always_ff @(posedge clock) begin
    dx.pc         <= fd_pc;
    dx.uop        <= uop;
    dx.result     <= rs1_data;
    dx.store_data <= rs2_data;
  end

  // a load in execute cannot also redirect
  a_stall_redirect: assert property (@(posedge clock) disable iff (reset)
    !(fd_valid && stall && redirect));

endmodule

/* design/fetch_stage.sv */
// fetch stage holding the pc and the fetch to decode register
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               stall,
  input  logic               redirect,
  input  logic [`XLEN-1:0]   target,
  output logic [`XLEN-1:0]   imem_addr,
  input  logic [`INST_W-1:0] imem_data,
  output logic               fd_valid,
  output logic [`XLEN-1:0]   fd_pc,
  output logic [`INST_W-1:0] fd_inst
);

  logic [`XLEN-1:0] pc;

  assign imem_addr = pc;

  // redirect wins, the two never coincide
  always_ff @(posedge clock) begin
    if (reset) begin
      pc       <= `PC_RESET;
      fd_valid <= 1'b0;
    end else if (redirect) begin
      pc       <= target;
      fd_valid <= 1'b0;
    end else if (!stall) begin
      pc       <= pc + `XLEN'd4;
      fd_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall && !redirect) begin
      fd_pc   <= pc;
      fd_inst <= imem_data;
    end
  end

  // branch targets come from execute
  a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
    imem_addr[1:0] == 2'b00);

endmodule

/* design/stage_if.sv */
// pipeline register bundle passed from one stage to the next
`timescale 1ns/1ps
`include "core_params.svh"

interface stage_if import pipe_pkg::*; ();

  logic             valid;
  logic [`XLEN-1:0] pc;
  uop_t             uop;
  // alu result, load data, or rs1 value out of decode
  logic [`XLEN-1:0] result;
  logic [`XLEN-1:0] store_data;

  modport source (
    output valid, pc, uop, result, store_data
  );

  modport sink (
    input valid, pc, uop, result, store_data
  );

  // forwarding taps
  modport monitor (
    input valid, pc, uop, result, store_data
  );

endinterface

/* design/pipe_pkg.sv */
// pipeline types for the decoded micro-op and operand forwarding
`include "core_params.svh"

package pipe_pkg;
  import isa_pkg::*;

  // one decoded instruction as it moves down the pipe
  typedef struct packed {
    alu_op_e                alu_op;
    branch_e                branch;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic                   use_imm;
    logic [`XLEN-1:0]       imm;
  } uop_t;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

endpackage

/* design/isa_pkg.sv */
// instruction set encodings for the rv64i subset
package isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  // resolved in execute
  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JUMP
  } branch_e;

endpackage

/* design/core_params.svh */
// core width and reset macros shared by the rv64 pipeline
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 64

// instruction word
`define INST_W 32

// register file
`define REG_ADDR_W 5
`define NUM_REGS 32
`define SHAMT_W 6

// first fetch address after reset
`define PC_RESET 64'h0

`endif
